/* char_draw.f */
+incdir+.
char_draw_pkg.sv
draw_cmd_regs.sv
glyph_rom.sv
glyph_hit.sv
char_scanner.sv
pixel_writer.sv
char_draw_top.sv
tb_char_draw.sv

/* char_draw_pkg.sv */
package char_draw_pkg;

    // Bitmap geometry
    localparam int GLYPH_COLS = 5;
    localparam int GLYPH_ROWS = 9;

    // Box adds one margin cell on the left and on top
    localparam int BOX_COLS = GLYPH_COLS + 1;
    localparam int BOX_ROWS = GLYPH_ROWS + 1;

    typedef logic [9:0]  pixel_x_t;      // Pixel column
    typedef logic [8:0]  pixel_y_t;      // Pixel row
    typedef logic [18:0] vga_addr_t;     // Frame-buffer word address
    typedef logic [7:0]  color_id_t;     // Palette index
    typedef logic [7:0]  char_code_t;
    typedef logic [3:0]  glyph_size_t;   // Scale minus one

    // Bit 4 is the leftmost column
    typedef logic [GLYPH_COLS-1:0] glyph_row_t;

    // Row 0 sits in the top bits
    typedef logic [GLYPH_ROWS*GLYPH_COLS-1:0] glyph_bitmap_t;

    typedef enum logic [1:0] {
        MODE_PLACE    = 2'd0,   // Code and origin only
        MODE_STYLE    = 2'd1,   // Colors and size, then draw
        MODE_FULL     = 2'd2,
        MODE_FULL_ALT = 2'd3
    } cmd_mode_e;

endpackage

/* char_draw_top.sv */
`timescale 1ns/1ps

module char_draw_top #(
    parameter int SCREEN_W = 640,
    parameter int SCREEN_H = 480
) (
    input  logic                       clk,
    input  logic                       rst,
    input  char_draw_pkg::pixel_x_t    x,
    input  char_draw_pkg::pixel_y_t    y,
    input  char_draw_pkg::char_code_t  code,
    input  char_draw_pkg::glyph_size_t size,
    input  logic [1:0]                 mode,
    input  char_draw_pkg::color_id_t   idata_fg,
    input  char_draw_pkg::color_id_t   idata_bg,
    input  logic                       idata_vld,
    output logic                       odone,
    output char_draw_pkg::vga_addr_t   oaddr,
    output char_draw_pkg::color_id_t   odata,
    output logic                       owren
);
    import char_draw_pkg::*;

    pixel_x_t      origin_x;
    pixel_y_t      origin_y;
    char_code_t    char_code;
    glyph_size_t   glyph_size;
    color_id_t     fg_color;
    color_id_t     bg_color;
    logic          start;
    glyph_bitmap_t bitmap;
    pixel_x_t      scan_x;
    pixel_y_t      scan_y;
    logic          scan_wren;
    logic          busy;
    logic          done;
    logic          fg_hit;

    draw_cmd_regs u_cmd_regs (
        .clk        (clk),
        .rst        (rst),
        .x          (x),
        .y          (y),
        .code       (code),
        .size       (size),
        .mode       (mode),
        .idata_fg   (idata_fg),
        .idata_bg   (idata_bg),
        .idata_vld  (idata_vld),
        .busy       (busy),
        .origin_x   (origin_x),
        .origin_y   (origin_y),
        .char_code  (char_code),
        .glyph_size (glyph_size),
        .fg_color   (fg_color),
        .bg_color   (bg_color),
        .start      (start)
    );

    glyph_rom u_glyph_rom (
        .clk       (clk),
        .char_code (char_code),
        .bitmap    (bitmap)
    );

    glyph_hit u_glyph_hit (
        .clk        (clk),
        .origin_x   (origin_x),
        .origin_y   (origin_y),
        .glyph_size (glyph_size),
        .bitmap     (bitmap),
        .scan_x     (scan_x),
        .scan_y     (scan_y),
        .fg_hit     (fg_hit)
    );

    char_scanner #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_scanner (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .origin_x   (origin_x),
        .origin_y   (origin_y),
        .glyph_size (glyph_size),
        .scan_x     (scan_x),
        .scan_y     (scan_y),
        .scan_wren  (scan_wren),
        .busy       (busy),
        .done       (done)
    );

    pixel_writer #(
        .SCREEN_W (SCREEN_W)
    ) u_writer (
        .clk       (clk),
        .rst       (rst),
        .scan_x    (scan_x),
        .scan_y    (scan_y),
        .scan_wren (scan_wren),
        .fg_hit    (fg_hit),
        .fg_color  (fg_color),
        .bg_color  (bg_color),
        .done      (done),
        .oaddr     (oaddr),
        .odata     (odata),
        .owren     (owren),
        .odone     (odone)
    );

endmodule

/* char_scanner.sv */
`timescale 1ns/1ps

module char_scanner #(
    parameter int SCREEN_W = 640,
    parameter int SCREEN_H = 480
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  char_draw_pkg::pixel_x_t    origin_x,
    input  char_draw_pkg::pixel_y_t    origin_y,
    input  char_draw_pkg::glyph_size_t glyph_size,
    output char_draw_pkg::pixel_x_t    scan_x,
    output char_draw_pkg::pixel_y_t    scan_y,
    output logic                       scan_wren,
    output logic                       busy,
    output logic                       done
);
    import char_draw_pkg::*;

    localparam int XW = $clog2(SCREEN_W);
    localparam int YW = $clog2(SCREEN_H);

    typedef logic [XW-1:0] corner_x_t;
    typedef logic [YW-1:0] corner_y_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,    // Bitmap and cell edges settle
        SCAN,
        FINISH
    } state_e;

    state_e    state;
    logic [4:0] scale;
    pixel_x_t  box_w;
    pixel_y_t  box_h;
    corner_x_t x1;
    corner_y_t y1;
    logic      row_end;
    logic      box_end;

    assign scale   = {1'b0, glyph_size} + 5'd1;
    assign box_w   = pixel_x_t'(BOX_COLS) * pixel_x_t'(scale);
    assign box_h   = pixel_y_t'(BOX_ROWS) * pixel_y_t'(scale);
    assign row_end = scan_x == pixel_x_t'(x1);
    assign box_end = row_end && (scan_y == pixel_y_t'(y1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= SETUP;
                    end
                end
                SETUP: state <= SCAN;
                SCAN: begin
                    if (box_end) begin
                        state <= FINISH;
                    end
                end
                FINISH: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            scan_x <= origin_x;
            scan_y <= origin_y;
            x1     <= corner_x_t'(origin_x + box_w - pixel_x_t'(1));
            y1     <= corner_y_t'(origin_y + box_h - pixel_y_t'(1));
        end else if (state == SCAN) begin
            if (row_end) begin
                scan_x <= origin_x;                // Wrap to next row
                scan_y <= scan_y + pixel_y_t'(1);
            end else begin
                scan_x <= scan_x + pixel_x_t'(1);
            end
        end
    end

    assign scan_wren = state == SCAN;
    assign busy      = state != IDLE;
    assign done      = state == FINISH;

endmodule

/* draw_cmd_regs.sv */
`timescale 1ns/1ps

module draw_cmd_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  char_draw_pkg::pixel_x_t    x,
    input  char_draw_pkg::pixel_y_t    y,
    input  char_draw_pkg::char_code_t  code,
    input  char_draw_pkg::glyph_size_t size,
    input  logic [1:0]                 mode,
    input  char_draw_pkg::color_id_t   idata_fg,
    input  char_draw_pkg::color_id_t   idata_bg,
    input  logic                       idata_vld,
    input  logic                       busy,
    output char_draw_pkg::pixel_x_t    origin_x,
    output char_draw_pkg::pixel_y_t    origin_y,
    output char_draw_pkg::char_code_t  char_code,
    output char_draw_pkg::glyph_size_t glyph_size,
    output char_draw_pkg::color_id_t   fg_color,
    output char_draw_pkg::color_id_t   bg_color,
    output logic                       start
);
    import char_draw_pkg::*;

    cmd_mode_e cmd_mode;
    logic      accept;

    assign cmd_mode = cmd_mode_e'(mode);
    assign accept   = idata_vld && !busy && !start;   // Scanner not yet busy on the start cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            origin_x   <= '0;
            origin_y   <= '0;
            char_code  <= '0;
            glyph_size <= '0;
            fg_color   <= '0;
            bg_color   <= '0;
            start      <= 1'b0;
        end else begin
            start <= accept && (cmd_mode != MODE_PLACE);
            if (accept) begin
                case (cmd_mode)
                    MODE_PLACE: begin
                        char_code <= code;
                        origin_x  <= x;
                        origin_y  <= y;
                    end
                    MODE_STYLE: begin
                        glyph_size <= size;
                        fg_color   <= idata_fg;
                        bg_color   <= idata_bg;
                    end
                    MODE_FULL, MODE_FULL_ALT: begin
                        char_code  <= code;
                        origin_x   <= x;
                        origin_y   <= y;
                        glyph_size <= size;
                        fg_color   <= idata_fg;
                        bg_color   <= idata_bg;
                    end
                endcase
            end
        end
    end

endmodule

/* glyph_hit.sv */
`timescale 1ns/1ps

module glyph_hit (
    input  logic                         clk,
    input  char_draw_pkg::pixel_x_t      origin_x,
    input  char_draw_pkg::pixel_y_t      origin_y,
    input  char_draw_pkg::glyph_size_t   glyph_size,
    input  char_draw_pkg::glyph_bitmap_t bitmap,
    input  char_draw_pkg::pixel_x_t      scan_x,
    input  char_draw_pkg::pixel_y_t      scan_y,
    output logic                         fg_hit
);
    import char_draw_pkg::*;

    logic [4:0]              scale;
    pixel_x_t                col_edge [GLYPH_COLS+1];   // Left edge of each bitmap column
    pixel_y_t                row_edge [GLYPH_ROWS+1];
    logic [GLYPH_COLS-1:0]   in_col;
    logic [GLYPH_ROWS-1:0]   in_row;

    assign scale = {1'b0, glyph_size} + 5'd1;

    // Edge k sits k+1 cells past the origin
    always_ff @(posedge clk) begin
        for (int k = 0; k <= GLYPH_COLS; k++) begin
            col_edge[k] <= origin_x + pixel_x_t'(k + 1) * pixel_x_t'(scale);
        end
        for (int k = 0; k <= GLYPH_ROWS; k++) begin
            row_edge[k] <= origin_y + pixel_y_t'(k + 1) * pixel_y_t'(scale);
        end
    end

    always_comb begin
        for (int j = 0; j < GLYPH_COLS; j++) begin
            in_col[j] = (scan_x >= col_edge[j]) && (scan_x < col_edge[j+1]);
        end
        for (int i = 0; i < GLYPH_ROWS; i++) begin
            in_row[i] = (scan_y >= row_edge[i]) && (scan_y < row_edge[i+1]);
        end
    end

    always_comb begin
        glyph_row_t row_bits;
        fg_hit = 1'b0;
        for (int i = 0; i < GLYPH_ROWS; i++) begin
            row_bits = bitmap[(GLYPH_ROWS-1-i)*GLYPH_COLS +: GLYPH_COLS];
            for (int j = 0; j < GLYPH_COLS; j++) begin
                fg_hit = fg_hit | (row_bits[GLYPH_COLS-1-j] & in_col[j] & in_row[i]);
            end
        end
    end

endmodule

/* glyph_rom.sv */
`timescale 1ns/1ps

module glyph_rom (
    input  logic                         clk,
    input  char_draw_pkg::char_code_t    char_code,
    output char_draw_pkg::glyph_bitmap_t bitmap
);

    // Rows listed top to bottom
    always_ff @(posedge clk) begin
        case (char_code)
            8'h30: bitmap <= {5'b01110, 5'b10001, 5'b10001, 5'b10001, 5'b10001,
                              5'b10001, 5'b10001, 5'b10001, 5'b01110};  // 0
            8'h31: bitmap <= {5'b00100, 5'b01100, 5'b00100, 5'b00100, 5'b00100,
                              5'b00100, 5'b00100, 5'b00100, 5'b01110};  // 1
            8'h32: bitmap <= {5'b01110, 5'b10001, 5'b10001, 5'b00001, 5'b00010,
                              5'b00100, 5'b01000, 5'b10000, 5'b11111};  // 2
            8'h33: bitmap <= {5'b01110, 5'b10001, 5'b10001, 5'b00001, 5'b00110,
                              5'b00001, 5'b10001, 5'b10001, 5'b01110};  // 3
            8'h34: bitmap <= {5'b00010, 5'b00110, 5'b00110, 5'b01010, 5'b01010,
                              5'b10010, 5'b11111, 5'b00010, 5'b00010};  // 4
            8'h35: bitmap <= {5'b11111, 5'b10000, 5'b10000, 5'b11110, 5'b10001,
                              5'b00001, 5'b00001, 5'b10001, 5'b01110};  // 5
            8'h36: bitmap <= {5'b00110, 5'b01000, 5'b10000, 5'b11110, 5'b10001,
                              5'b10001, 5'b10001, 5'b10001, 5'b01110};  // 6
            8'h37: bitmap <= {5'b11111, 5'b10001, 5'b00001, 5'b00010, 5'b00010,
                              5'b00010, 5'b00100, 5'b00100, 5'b00100};  // 7
            8'h38: bitmap <= {5'b01110, 5'b10001, 5'b10001, 5'b10001, 5'b01110,
                              5'b10001, 5'b10001, 5'b10001, 5'b01110};  // 8
            8'h39: bitmap <= {5'b01110, 5'b10001, 5'b10001, 5'b10001, 5'b01111,
                              5'b00001, 5'b00001, 5'b00010, 5'b01100};  // 9
            8'h3A: bitmap <= {5'b00000, 5'b00000, 5'b00100, 5'b00000, 5'b00000,
                              5'b00000, 5'b00000, 5'b00100, 5'b00000};  // Colon
            8'h41: bitmap <= {5'b00100, 5'b01010, 5'b10001, 5'b10001, 5'b11111,
                              5'b10001, 5'b10001, 5'b10001, 5'b10001};  // A
            8'h43: bitmap <= {5'b01110, 5'b10001, 5'b10000, 5'b10000, 5'b10000,
                              5'b10000, 5'b10000, 5'b10001, 5'b01110};  // C
            8'h44: bitmap <= {5'b11110, 5'b10001, 5'b10001, 5'b10001, 5'b10001,
                              5'b10001, 5'b10001, 5'b10001, 5'b11110};  // D
            8'h45: bitmap <= {5'b11111, 5'b10000, 5'b10000, 5'b10000, 5'b11111,
                              5'b10000, 5'b10000, 5'b10000, 5'b11111};  // E
            8'h47: bitmap <= {5'b01110, 5'b10001, 5'b10000, 5'b10000, 5'b10000,
                              5'b10111, 5'b10001, 5'b10011, 5'b01101};  // G
            8'h49: bitmap <= {5'b01110, 5'b00100, 5'b00100, 5'b00100, 5'b00100,
                              5'b00100, 5'b00100, 5'b00100, 5'b01110};  // I
            8'h4B: bitmap <= {5'b10001, 5'b10010, 5'b10100, 5'b11000, 5'b11000,
                              5'b10100, 5'b10010, 5'b10001, 5'b10001};  // K
            8'h4C: bitmap <= {5'b10000, 5'b10000, 5'b10000, 5'b10000, 5'b10000,
                              5'b10000, 5'b10000, 5'b10000, 5'b11111};  // L
            8'h4D: bitmap <= {5'b10001, 5'b11011, 5'b10101, 5'b10001, 5'b10001,
                              5'b10001, 5'b10001, 5'b10001, 5'b10001};  // M
            8'h4E: bitmap <= {5'b10001, 5'b11001, 5'b10101, 5'b10011, 5'b10001,
                              5'b10001, 5'b10001, 5'b10001, 5'b10001};  // N
            8'h4F: bitmap <= {5'b01110, 5'b10001, 5'b10001, 5'b10001, 5'b10001,
                              5'b10001, 5'b10001, 5'b10001, 5'b01110};  // O
            8'h50: bitmap <= {5'b11110, 5'b10001, 5'b10001, 5'b10001, 5'b11110,
                              5'b10000, 5'b10000, 5'b10000, 5'b10000};  // P
            8'h52: bitmap <= {5'b11110, 5'b10001, 5'b10001, 5'b10001, 5'b11110,
                              5'b10100, 5'b10010, 5'b10001, 5'b10001};  // R
            8'h53: bitmap <= {5'b01110, 5'b10001, 5'b10000, 5'b11000, 5'b01110,
                              5'b00011, 5'b00001, 5'b10001, 5'b01110};  // S
            8'h54: bitmap <= {5'b11111, 5'b00100, 5'b00100, 5'b00100, 5'b00100,
                              5'b00100, 5'b00100, 5'b00100, 5'b00100};  // T
            8'h56: bitmap <= {5'b10001, 5'b10001, 5'b10001, 5'b10001, 5'b10001,
                              5'b10001, 5'b10001, 5'b01010, 5'b00100};  // V
            8'h59: bitmap <= {5'b10001, 5'b10001, 5'b01010, 5'b01010, 5'b00100,
                              5'b00100, 5'b00100, 5'b00100, 5'b00100};  // Y
            default: bitmap <= {40'd0, 5'b01111};                        // Underscore-like mark
        endcase
    end

endmodule

/* pixel_writer.sv */
`timescale 1ns/1ps

module pixel_writer #(
    parameter int SCREEN_W = 640
) (
    input  logic                     clk,
    input  logic                     rst,
    input  char_draw_pkg::pixel_x_t  scan_x,
    input  char_draw_pkg::pixel_y_t  scan_y,
    input  logic                     scan_wren,
    input  logic                     fg_hit,
    input  char_draw_pkg::color_id_t fg_color,
    input  char_draw_pkg::color_id_t bg_color,
    input  logic                     done,
    output char_draw_pkg::vga_addr_t oaddr,
    output char_draw_pkg::color_id_t odata,
    output logic                     owren,
    output logic                     odone
);
    import char_draw_pkg::*;

    vga_addr_t addr;

    assign addr = vga_addr_t'(scan_y) * vga_addr_t'(SCREEN_W) + vga_addr_t'(scan_x);

    always_ff @(posedge clk) begin
        if (rst) begin
            oaddr <= '0;
            odata <= '0;
            owren <= 1'b0;
            odone <= 1'b0;
        end else begin
            oaddr <= scan_wren ? addr : '0;                           // Bus idles at zero
            odata <= scan_wren ? (fg_hit ? fg_color : bg_color) : '0;
            owren <= scan_wren;
            odone <= done;                                            // Stays aligned with data
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench, exit status follows the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_char_draw \
    -f char_draw.f -o tb_char_draw &&
./obj_dir/tb_char_draw ||
exit 1

/* tb_glyph_model.svh */
`ifndef TB_GLYPH_MODEL_SVH
`define TB_GLYPH_MODEL_SVH

// Nine rows of five bits, top row in the high bits, leftmost column first
function automatic logic [44:0] model_bitmap(input logic [7:0] c);
    logic [44:0] g;
    case (c)
        8'h30: g = 45'b01110_10001_10001_10001_10001_10001_10001_10001_01110;
        8'h31: g = 45'b00100_01100_00100_00100_00100_00100_00100_00100_01110;
        8'h32: g = 45'b01110_10001_10001_00001_00010_00100_01000_10000_11111;
        8'h33: g = 45'b01110_10001_10001_00001_00110_00001_10001_10001_01110;
        8'h34: g = 45'b00010_00110_00110_01010_01010_10010_11111_00010_00010;
        8'h35: g = 45'b11111_10000_10000_11110_10001_00001_00001_10001_01110;
        8'h36: g = 45'b00110_01000_10000_11110_10001_10001_10001_10001_01110;
        8'h37: g = 45'b11111_10001_00001_00010_00010_00010_00100_00100_00100;
        8'h38: g = 45'b01110_10001_10001_10001_01110_10001_10001_10001_01110;
        8'h39: g = 45'b01110_10001_10001_10001_01111_00001_00001_00010_01100;
        8'h3A: g = 45'b00000_00000_00100_00000_00000_00000_00000_00100_00000;
        8'h41: g = 45'b00100_01010_10001_10001_11111_10001_10001_10001_10001;
        8'h43: g = 45'b01110_10001_10000_10000_10000_10000_10000_10001_01110;
        8'h44: g = 45'b11110_10001_10001_10001_10001_10001_10001_10001_11110;
        8'h45: g = 45'b11111_10000_10000_10000_11111_10000_10000_10000_11111;
        8'h47: g = 45'b01110_10001_10000_10000_10000_10111_10001_10011_01101;
        8'h49: g = 45'b01110_00100_00100_00100_00100_00100_00100_00100_01110;
        8'h4B: g = 45'b10001_10010_10100_11000_11000_10100_10010_10001_10001;
        8'h4C: g = 45'b10000_10000_10000_10000_10000_10000_10000_10000_11111;
        8'h4D: g = 45'b10001_11011_10101_10001_10001_10001_10001_10001_10001;
        8'h4E: g = 45'b10001_11001_10101_10011_10001_10001_10001_10001_10001;
        8'h4F: g = 45'b01110_10001_10001_10001_10001_10001_10001_10001_01110;
        8'h50: g = 45'b11110_10001_10001_10001_11110_10000_10000_10000_10000;
        8'h52: g = 45'b11110_10001_10001_10001_11110_10100_10010_10001_10001;
        8'h53: g = 45'b01110_10001_10000_11000_01110_00011_00001_10001_01110;
        8'h54: g = 45'b11111_00100_00100_00100_00100_00100_00100_00100_00100;
        8'h56: g = 45'b10001_10001_10001_10001_10001_10001_10001_01010_00100;
        8'h59: g = 45'b10001_10001_01010_01010_00100_00100_00100_00100_00100;
        default: g = 45'b00000_00000_00000_00000_00000_00000_00000_00000_01111;
    endcase
    return g;
endfunction

// Color of box pixel (col, row), counted from the box corner
function automatic logic [7:0] model_color(input logic [7:0] c, input int s, input int col,
        input int row, input logic [7:0] fg, input logic [7:0] bg);
    logic [44:0] g;
    int gc;
    int gr;
    g = model_bitmap(c);
    gc = col / (s + 1) - 1;   // Margin cell gives -1
    gr = row / (s + 1) - 1;
    if (gc < 0 || gr < 0) return bg;
    return g[(8 - gr) * 5 + (4 - gc)] ? fg : bg;
endfunction

localparam logic [7:0] KEPT_CODES [28] = '{
    8'h30, 8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'h37, 8'h38, 8'h39, 8'h3A,
    8'h41, 8'h43, 8'h44, 8'h45, 8'h47, 8'h49, 8'h4B, 8'h4C, 8'h4D, 8'h4E, 8'h4F,
    8'h50, 8'h52, 8'h53, 8'h54, 8'h56, 8'h59
};

`endif

/* tb_char_draw.sv */
`timescale 1ns/1ps

module tb_char_draw;
    import char_draw_pkg::*;

    `include "tb_glyph_model.svh"

    localparam int SCREEN_W     = 640;
    localparam int SCREEN_H     = 480;
    localparam int NUM_RAND     = 20;
    localparam int CMD_SLACK    = 20;
    localparam int RESET_CYCLES = 8;

    logic        clk;
    logic        rst;
    pixel_x_t    x;
    pixel_y_t    y;
    char_code_t  code;
    glyph_size_t size;
    logic [1:0]  mode;
    color_id_t   idata_fg;
    color_id_t   idata_bg;
    logic        idata_vld;
    logic        odone;
    vga_addr_t   oaddr;
    color_id_t   odata;
    logic        owren;

    // Draw in flight as the model sees it
    int         exp_x0;
    int         exp_y0;
    int         exp_size;
    char_code_t exp_code;
    color_id_t  exp_fg;
    color_id_t  exp_bg;
    int         exp_count;
    int         wr_idx;     // Writes seen in the current draw

    int         rnd_x [NUM_RAND];
    int         rnd_y [NUM_RAND];
    int         rnd_size [NUM_RAND];
    char_code_t rnd_code [NUM_RAND];
    color_id_t  rnd_fg [NUM_RAND];
    color_id_t  rnd_bg [NUM_RAND];
    cmd_mode_e  rnd_mode [NUM_RAND];

    char_draw_top DUT (
        .clk       (clk),
        .rst       (rst),
        .x         (x),
        .y         (y),
        .code      (code),
        .size      (size),
        .mode      (mode),
        .idata_fg  (idata_fg),
        .idata_bg  (idata_bg),
        .idata_vld (idata_vld),
        .odone     (odone),
        .oaddr     (oaddr),
        .odata     (odata),
        .owren     (owren)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    function automatic int draw_len(input int s);
        return (6 * (s + 1)) * (10 * (s + 1));
    endfunction

    task automatic apply_reset();
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        assert (!owren && !odone) else fail_run("Write strobe or done pulse high after reset");
    endtask

    task automatic expect_draw(input int cx, input int cy, input logic [7:0] c, input int s,
            input logic [7:0] fg, input logic [7:0] bg);
        exp_x0 = cx;
        exp_y0 = cy;
        exp_code = c;
        exp_size = s;
        exp_fg = fg;
        exp_bg = bg;
        exp_count = draw_len(s);
    endtask

    // One cycle of idata_vld, returns on the next falling edge
    task automatic send_cmd(input logic [1:0] m, input int cx, input int cy, input logic [7:0] c,
            input int s, input logic [7:0] fg, input logic [7:0] bg);
        mode = m;
        x = pixel_x_t'(cx);
        y = pixel_y_t'(cy);
        code = c;
        size = glyph_size_t'(s);
        idata_fg = fg;
        idata_bg = bg;
        idata_vld = 1'b1;
        @(negedge clk);
        idata_vld = 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!odone) begin
            @(negedge clk);
            waited++;
            if (waited > exp_count + CMD_SLACK) fail_run("No done pulse after the draw");
        end
        @(negedge clk);  // Done checks sample the count on this edge
        exp_count = 0;   // Any later write is unexpected
    endtask

    task automatic draw_cmd(input logic [1:0] m, input int cx, input int cy, input logic [7:0] c,
            input int s, input logic [7:0] fg, input logic [7:0] bg);
        expect_draw(cx, cy, c, s, fg, bg);
        send_cmd(m, cx, cy, c, s, fg, bg);
        wait_done();
    endtask

    // Write monitor, expected order is row-major
    always @(posedge clk) begin
        int        box_w;
        int        col;
        int        row;
        vga_addr_t exp_addr;
        color_id_t exp_data;
        if (rst) begin
            wr_idx <= 0;
        end
        if (!rst && owren) begin
            box_w = 6 * (exp_size + 1);
            col = wr_idx % box_w;
            row = wr_idx / box_w;
            exp_addr = vga_addr_t'((exp_y0 + row) * SCREEN_W + exp_x0 + col);
            exp_data = model_color(exp_code, exp_size, col, row, exp_fg, exp_bg);
            assert (wr_idx < exp_count)
                else fail_run($sformatf("Unexpected write at time %0t", $time));
            assert (oaddr == exp_addr && odata == exp_data)
                else fail_run($sformatf("Mismatch at %0t: write %0d addr %0d data %h, exp %0d %h",
                    $time, wr_idx, oaddr, odata, exp_addr, exp_data));
            wr_idx <= wr_idx + 1;
        end
        if (!rst && odone) begin
            wr_idx <= 0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !owren |-> (oaddr == '0 && odata == '0))
        else fail_run("Address or data not zero while the write strobe is low");
    assert property (@(posedge clk) disable iff (rst) (odone || $past(odone)) |-> !owren)
        else fail_run("Write strobe high at or after the done pulse");
    assert property (@(posedge clk) disable iff (rst)
            odone |-> (exp_count > 0 && wr_idx == exp_count))
        else fail_run("Done pulse before the expected number of writes");
    assert property (@(posedge clk) disable iff (rst) $fell(owren) |-> odone)
        else fail_run("Done pulse missing right after the last write");

    initial begin
        int budget;
        int pick;
        void'($urandom(28));
        rst = 1'b1;
        x = '0;
        y = '0;
        code = '0;
        size = '0;
        mode = '0;
        idata_fg = '0;
        idata_bg = '0;
        idata_vld = 1'b0;
        exp_count = 0;
        budget = draw_len(0) + draw_len(2) + draw_len(1) + draw_len(0) + draw_len(1);
        for (int k = 0; k < NUM_RAND; k++) begin
            rnd_size[k] = $urandom % 4;
            pick = $urandom % 28;
            rnd_code[k] = KEPT_CODES[pick];
            rnd_x[k] = $urandom % (SCREEN_W - 6 * (rnd_size[k] + 1) + 1);
            rnd_y[k] = $urandom % (SCREEN_H - 10 * (rnd_size[k] + 1) + 1);
            rnd_fg[k] = color_id_t'($urandom);
            rnd_bg[k] = color_id_t'($urandom);
            rnd_mode[k] = ($urandom % 2 == 0) ? MODE_FULL : MODE_FULL_ALT;
            budget += draw_len(rnd_size[k]);
        end
        budget += (8 + NUM_RAND) * CMD_SLACK + 2 * RESET_CYCLES;
        fork
            begin
                repeat (2 * budget) @(posedge clk);
                fail_run("Watchdog expired before the tests finished");
            end
        join_none

        apply_reset();
        draw_cmd(MODE_FULL, 100, 50, 8'h38, 0, 8'h0F, 8'h01);
        draw_cmd(MODE_FULL, 300, 200, 8'h4D, 2, 8'hA5, 8'h5A);

        // Place alone must not draw
        send_cmd(MODE_PLACE, 20, 30, 8'h33, 3, 8'hFF, 8'hFF);
        repeat (10) @(negedge clk);
        expect_draw(20, 30, 8'h33, 1, 8'h22, 8'h44);
        send_cmd(MODE_STYLE, 400, 400, 8'h41, 1, 8'h22, 8'h44);
        wait_done();

        draw_cmd(MODE_FULL, 600, 400, 8'h7E, 0, 8'hC3, 8'h3C);   // Default glyph

        // Reset lands in the middle of a draw
        expect_draw(200, 100, 8'h4F, 1, 8'h12, 8'h34);
        send_cmd(MODE_FULL, 200, 100, 8'h4F, 1, 8'h12, 8'h34);
        repeat (20) @(negedge clk);
        apply_reset();
        exp_count = 0;

        expect_draw(50, 300, 8'h47, 1, 8'h11, 8'h99);
        send_cmd(MODE_FULL, 50, 300, 8'h47, 1, 8'h11, 8'h99);
        repeat (10) @(negedge clk);
        send_cmd(MODE_FULL, 500, 100, 8'h41, 3, 8'h77, 8'h88);   // Busy, dropped
        wait_done();
        repeat (10) @(negedge clk);

        for (int k = 0; k < NUM_RAND; k++) begin
            draw_cmd(rnd_mode[k], rnd_x[k], rnd_y[k], rnd_code[k], rnd_size[k],
                rnd_fg[k], rnd_bg[k]);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule
